// ==== common/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// word addressing
`define ADDR_WIDTH 24
`define DATA_WIDTH 32

// block geometry
`define BLOCK_WORDS 4
`define OFFSET_WIDTH 2

// blocks per cache, split over two ways
`define CACHE_BLOCK_CAPACITY 128

// credits the external memory grants after reset
`define MEM_CREDITS 2

`endif

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// cache controller states
	typedef enum logic [2:0] {
		state_idle      = 3'd0,
		state_lookup    = 3'd1,
		state_fill_req  = 3'd2,
		state_fill      = 3'd3,
		state_write_req = 3'd4,
		state_respond   = 3'd5
	} cache_state_t;

	// which cache an outstanding block read belongs to
	typedef enum logic {
		owner_icache = 1'b0,
		owner_dcache = 1'b1
	} owner_t;

endpackage

`default_nettype wire

// ==== cache/cache_two_way_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_two_way_fifo #(
	parameter int CACHE_BLOCK_CAPACITY = `CACHE_BLOCK_CAPACITY
) (
	input  wire                    clock_i,
	input  wire                    rst_i,

	// core side
	input  wire                    core_req_i,
	input  wire                    core_rw_i,
	input  wire [`ADDR_WIDTH-1:0]  core_add_i,
	input  wire [`DATA_WIDTH-1:0]  core_data_i,
	output logic                   core_done_o,
	output logic [`DATA_WIDTH-1:0] core_data_o,

	// arbiter side
	output logic                   miss_req_o,
	output logic                   miss_rw_o,
	output logic                   miss_block_o,
	output logic [`ADDR_WIDTH-1:0] miss_add_o,
	output logic [`DATA_WIDTH-1:0] miss_data_o,
	input  wire                    miss_grant_i,
	input  wire                    fill_valid_i,
	input  wire [`DATA_WIDTH-1:0]  fill_data_i
);

	localparam int SETS    = CACHE_BLOCK_CAPACITY / 2;
	localparam int INDEX_W = $clog2(SETS);
	localparam int OFF_W   = `OFFSET_WIDTH;
	localparam int TAG_W   = `ADDR_WIDTH - INDEX_W - OFF_W;

	// storage
	// ----------------------------------------------------------------------
	logic [`DATA_WIDTH-1:0] data_mem [SETS][2][`BLOCK_WORDS];
	logic [TAG_W-1:0]       tag_mem  [SETS][2];
	logic [1:0]             valid_q  [SETS];
	// way to replace next, one bit per set
	logic [SETS-1:0]        fifo_ptr_q;

	cache_pkg::cache_state_t state_q;
	logic                    req_rw_q;
	logic [`ADDR_WIDTH-1:0]  req_add_q;
	logic [`DATA_WIDTH-1:0]  req_data_q;
	logic [`DATA_WIDTH-1:0]  rdata_q;
	logic [OFF_W-1:0]        beat_q;

	logic [TAG_W-1:0]   req_tag;
	logic [INDEX_W-1:0] req_index;
	logic [OFF_W-1:0]   req_off;
	logic               hit_way0, hit_way1, hit;
	logic               fill_way;
	logic               last_beat;

	assign req_tag   = req_add_q[`ADDR_WIDTH-1 -: TAG_W];
	assign req_index = req_add_q[OFF_W +: INDEX_W];
	assign req_off   = req_add_q[OFF_W-1:0];

	assign hit_way0  = valid_q[req_index][0] && (tag_mem[req_index][0] == req_tag);
	assign hit_way1  = valid_q[req_index][1] && (tag_mem[req_index][1] == req_tag);
	assign hit       = hit_way0 || hit_way1;
	assign fill_way  = fifo_ptr_q[req_index];
	assign last_beat = fill_valid_i && (beat_q == OFF_W'(`BLOCK_WORDS - 1));

	// controller
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q    <= cache_pkg::state_idle;
			beat_q     <= '0;
			fifo_ptr_q <= '0;
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= 2'b00;
			end
		end else begin
			case (state_q)
				cache_pkg::state_idle: begin
					if (core_req_i)
						state_q <= cache_pkg::state_lookup;
				end
				cache_pkg::state_lookup: begin
					// writes always go out, reads only on a miss
					if (req_rw_q)
						state_q <= cache_pkg::state_write_req;
					else if (hit)
						state_q <= cache_pkg::state_respond;
					else
						state_q <= cache_pkg::state_fill_req;
				end
				cache_pkg::state_fill_req: begin
					if (miss_grant_i) begin
						state_q <= cache_pkg::state_fill;
						beat_q  <= '0;
					end
				end
				cache_pkg::state_fill: begin
					if (fill_valid_i)
						beat_q <= beat_q + 1'b1;
					if (last_beat) begin
						valid_q[req_index][fill_way] <= 1'b1;
						fifo_ptr_q[req_index]        <= ~fill_way;
						state_q                      <= cache_pkg::state_respond;
					end
				end
				cache_pkg::state_write_req: begin
					if (miss_grant_i)
						state_q <= cache_pkg::state_respond;
				end
				default: state_q <= cache_pkg::state_idle;
			endcase
		end
	end

	// request capture and array updates
	always_ff @(posedge clock_i) begin
		if (state_q == cache_pkg::state_idle) begin
			req_rw_q   <= core_rw_i;
			req_add_q  <= core_add_i;
			req_data_q <= core_data_i;
		end
		if (state_q == cache_pkg::state_lookup) begin
			rdata_q <= hit_way1 ? data_mem[req_index][1][req_off]
				: data_mem[req_index][0][req_off];
			// write hit updates the word in place
			if (req_rw_q && hit)
				data_mem[req_index][hit_way1][req_off] <= req_data_q;
		end
		if ((state_q == cache_pkg::state_fill) && fill_valid_i) begin
			data_mem[req_index][fill_way][beat_q] <= fill_data_i;
			if (beat_q == req_off)
				rdata_q <= fill_data_i;
			if (last_beat)
				tag_mem[req_index][fill_way] <= req_tag;
		end
	end

	// outputs
	// ----------------------------------------------------------------------
	assign core_done_o  = (state_q == cache_pkg::state_respond);
	assign core_data_o  = rdata_q;

	assign miss_req_o   = (state_q == cache_pkg::state_fill_req)
		|| (state_q == cache_pkg::state_write_req);
	assign miss_rw_o    = req_rw_q;
	assign miss_block_o = ~req_rw_q;
	// block reads are aligned, writes carry the word address
	assign miss_add_o   = req_rw_q ? req_add_q
		: {req_add_q[`ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};
	assign miss_data_o  = req_data_q;

endmodule

`default_nettype wire

// ==== verilog/memory_arbiter.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "cache_settings.svh"

module memory_arbiter (
	input  wire                    clock_i,
	input  wire                    rst_i,

	// instruction cache
	input  wire                    ic_miss_req_i,
	input  wire                    ic_miss_rw_i,
	input  wire                    ic_miss_block_i,
	input  wire [`ADDR_WIDTH-1:0]  ic_miss_add_i,
	input  wire [`DATA_WIDTH-1:0]  ic_miss_data_i,
	output logic                   ic_miss_grant_o,
	output logic                   ic_fill_valid_o,
	output logic [`DATA_WIDTH-1:0] ic_fill_data_o,

	// data cache
	input  wire                    dc_miss_req_i,
	input  wire                    dc_miss_rw_i,
	input  wire                    dc_miss_block_i,
	input  wire [`ADDR_WIDTH-1:0]  dc_miss_add_i,
	input  wire [`DATA_WIDTH-1:0]  dc_miss_data_i,
	output logic                   dc_miss_grant_o,
	output logic                   dc_fill_valid_o,
	output logic [`DATA_WIDTH-1:0] dc_fill_data_o,

	// external memory
	output logic                   mem_req_o,
	output logic                   mem_rw_o,
	output logic                   mem_block_o,
	output logic [`ADDR_WIDTH-1:0] mem_add_o,
	output logic [`DATA_WIDTH-1:0] mem_data_o,
	input  wire                    mem_credit_i,
	input  wire                    mem_valid_i,
	input  wire [`DATA_WIDTH-1:0]  mem_data_i
);

	localparam int CREDIT_W = $clog2(`MEM_CREDITS + 1);
	localparam int PTR_W    = (`MEM_CREDITS > 1) ? $clog2(`MEM_CREDITS) : 1;

	logic [CREDIT_W-1:0]      credit_q;
	cache_pkg::owner_t        last_grant_q;
	cache_pkg::owner_t        owner_fifo [`MEM_CREDITS];
	logic [PTR_W-1:0]         wr_ptr_q, rd_ptr_q;
	logic [`OFFSET_WIDTH-1:0] beat_q;

	logic ic_elig, dc_elig, grant_any, push_owner, pop_owner;
	cache_pkg::owner_t grant_sel;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`MEM_CREDITS - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// a cache stays ineligible during its own grant cycle
	assign ic_elig   = ic_miss_req_i && !ic_miss_grant_o;
	assign dc_elig   = dc_miss_req_i && !dc_miss_grant_o;
	assign grant_any = (ic_elig || dc_elig) && (credit_q != '0);

	// round robin
	always_comb begin
		if (ic_elig && dc_elig)
			grant_sel = (last_grant_q == cache_pkg::owner_icache) ? cache_pkg::owner_dcache
				: cache_pkg::owner_icache;
		else if (dc_elig)
			grant_sel = cache_pkg::owner_dcache;
		else
			grant_sel = cache_pkg::owner_icache;
	end

	assign push_owner = grant_any && ((grant_sel == cache_pkg::owner_icache)
		? (ic_miss_block_i && !ic_miss_rw_i) : (dc_miss_block_i && !dc_miss_rw_i));
	assign pop_owner  = mem_valid_i && (beat_q == `OFFSET_WIDTH'(`BLOCK_WORDS - 1));

	// credits, grants and owner FIFO pointers
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			credit_q        <= CREDIT_W'(`MEM_CREDITS);
			last_grant_q    <= cache_pkg::owner_dcache;
			ic_miss_grant_o <= 1'b0;
			dc_miss_grant_o <= 1'b0;
			mem_req_o       <= 1'b0;
			wr_ptr_q        <= '0;
			rd_ptr_q        <= '0;
			beat_q          <= '0;
		end else begin
			credit_q        <= credit_q + CREDIT_W'(mem_credit_i) - CREDIT_W'(grant_any);
			ic_miss_grant_o <= grant_any && (grant_sel == cache_pkg::owner_icache);
			dc_miss_grant_o <= grant_any && (grant_sel == cache_pkg::owner_dcache);
			mem_req_o       <= grant_any;
			if (grant_any)
				last_grant_q <= grant_sel;
			if (push_owner)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (mem_valid_i)
				beat_q <= beat_q + 1'b1;
			if (pop_owner)
				rd_ptr_q <= next_ptr(rd_ptr_q);
		end
	end

	// request payload and owner entries
	always_ff @(posedge clock_i) begin
		if (grant_any) begin
			if (grant_sel == cache_pkg::owner_icache) begin
				mem_rw_o    <= ic_miss_rw_i;
				mem_block_o <= ic_miss_block_i;
				mem_add_o   <= ic_miss_add_i;
				mem_data_o  <= ic_miss_data_i;
			end else begin
				mem_rw_o    <= dc_miss_rw_i;
				mem_block_o <= dc_miss_block_i;
				mem_add_o   <= dc_miss_add_i;
				mem_data_o  <= dc_miss_data_i;
			end
		end
		if (push_owner)
			owner_fifo[wr_ptr_q] <= grant_sel;
	end

	// return path, steered by the oldest outstanding read
	// ----------------------------------------------------------------------
	assign ic_fill_valid_o = mem_valid_i && (owner_fifo[rd_ptr_q] == cache_pkg::owner_icache);
	assign dc_fill_valid_o = mem_valid_i && (owner_fifo[rd_ptr_q] == cache_pkg::owner_dcache);
	assign ic_fill_data_o  = mem_data_i;
	assign dc_fill_data_o  = mem_data_i;

endmodule

`default_nettype wire

// ==== verilog/internal_memory_system.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "cache_settings.svh"

module internal_memory_system (
	input  wire                    clock_i,
	input  wire                    rst_i,

	// instruction references
	input  wire                    i_core_req_i,
	input  wire                    i_core_rw_i,
	input  wire [`ADDR_WIDTH-1:0]  i_core_add_i,
	input  wire [`DATA_WIDTH-1:0]  i_core_data_i,
	output wire                    i_core_done_o,
	output wire [`DATA_WIDTH-1:0]  i_core_data_o,

	// data references
	input  wire                    d_core_req_i,
	input  wire                    d_core_rw_i,
	input  wire [`ADDR_WIDTH-1:0]  d_core_add_i,
	input  wire [`DATA_WIDTH-1:0]  d_core_data_i,
	output wire                    d_core_done_o,
	output wire [`DATA_WIDTH-1:0]  d_core_data_o,

	// external memory
	output wire                    mem_req_o,
	output wire                    mem_rw_o,
	output wire                    mem_block_o,
	output wire [`ADDR_WIDTH-1:0]  mem_add_o,
	output wire [`DATA_WIDTH-1:0]  mem_data_o,
	input  wire                    mem_credit_i,
	input  wire                    mem_valid_i,
	input  wire [`DATA_WIDTH-1:0]  mem_data_i
);

	// cache to arbiter
	// ----------------------------------------------------------------------
	wire                   ic_miss_req, ic_miss_rw, ic_miss_block, ic_miss_grant, ic_fill_valid;
	wire [`ADDR_WIDTH-1:0] ic_miss_add;
	wire [`DATA_WIDTH-1:0] ic_miss_data, ic_fill_data;
	wire                   dc_miss_req, dc_miss_rw, dc_miss_block, dc_miss_grant, dc_fill_valid;
	wire [`ADDR_WIDTH-1:0] dc_miss_add;
	wire [`DATA_WIDTH-1:0] dc_miss_data, dc_fill_data;

	// instruction cache
	cache_two_way_fifo #(.CACHE_BLOCK_CAPACITY(`CACHE_BLOCK_CAPACITY)) inst_cache (
		.clock_i      (clock_i),
		.rst_i        (rst_i),
		.core_req_i   (i_core_req_i),
		.core_rw_i    (i_core_rw_i),
		.core_add_i   (i_core_add_i),
		.core_data_i  (i_core_data_i),
		.core_done_o  (i_core_done_o),
		.core_data_o  (i_core_data_o),
		.miss_req_o   (ic_miss_req),
		.miss_rw_o    (ic_miss_rw),
		.miss_block_o (ic_miss_block),
		.miss_add_o   (ic_miss_add),
		.miss_data_o  (ic_miss_data),
		.miss_grant_i (ic_miss_grant),
		.fill_valid_i (ic_fill_valid),
		.fill_data_i  (ic_fill_data)
	);

	// data cache
	cache_two_way_fifo #(.CACHE_BLOCK_CAPACITY(`CACHE_BLOCK_CAPACITY)) data_cache (
		.clock_i      (clock_i),
		.rst_i        (rst_i),
		.core_req_i   (d_core_req_i),
		.core_rw_i    (d_core_rw_i),
		.core_add_i   (d_core_add_i),
		.core_data_i  (d_core_data_i),
		.core_done_o  (d_core_done_o),
		.core_data_o  (d_core_data_o),
		.miss_req_o   (dc_miss_req),
		.miss_rw_o    (dc_miss_rw),
		.miss_block_o (dc_miss_block),
		.miss_add_o   (dc_miss_add),
		.miss_data_o  (dc_miss_data),
		.miss_grant_i (dc_miss_grant),
		.fill_valid_i (dc_fill_valid),
		.fill_data_i  (dc_fill_data)
	);

	// shared external port
	// ----------------------------------------------------------------------
	memory_arbiter mem_arb (
		.clock_i         (clock_i),
		.rst_i           (rst_i),
		.ic_miss_req_i   (ic_miss_req),
		.ic_miss_rw_i    (ic_miss_rw),
		.ic_miss_block_i (ic_miss_block),
		.ic_miss_add_i   (ic_miss_add),
		.ic_miss_data_i  (ic_miss_data),
		.ic_miss_grant_o (ic_miss_grant),
		.ic_fill_valid_o (ic_fill_valid),
		.ic_fill_data_o  (ic_fill_data),
		.dc_miss_req_i   (dc_miss_req),
		.dc_miss_rw_i    (dc_miss_rw),
		.dc_miss_block_i (dc_miss_block),
		.dc_miss_add_i   (dc_miss_add),
		.dc_miss_data_i  (dc_miss_data),
		.dc_miss_grant_o (dc_miss_grant),
		.dc_fill_valid_o (dc_fill_valid),
		.dc_fill_data_o  (dc_fill_data),
		.mem_req_o       (mem_req_o),
		.mem_rw_o        (mem_rw_o),
		.mem_block_o     (mem_block_o),
		.mem_add_o       (mem_add_o),
		.mem_data_o      (mem_data_o),
		.mem_credit_i    (mem_credit_i),
		.mem_valid_i     (mem_valid_i),
		.mem_data_i      (mem_data_i)
	);

endmodule

`default_nettype wire

// ==== verif/ext_memory_model.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "cache_settings.svh"

module ext_memory_model (
	input  wire                    clock_i,
	input  wire                    rst_i,
	// cycles between a consumed request and its credit
	input  wire [31:0]             credit_delay_i,
	input  wire                    mem_req_i,
	input  wire                    mem_rw_i,
	input  wire                    mem_block_i,
	input  wire [`ADDR_WIDTH-1:0]  mem_add_i,
	input  wire [`DATA_WIDTH-1:0]  mem_data_i,
	output logic                   mem_credit_o,
	output logic                   mem_valid_o,
	output logic [`DATA_WIDTH-1:0] mem_data_o
);

	logic [`DATA_WIDTH-1:0] store [logic [`ADDR_WIDTH-1:0]];
	logic [`DATA_WIDTH-1:0] beats [$];
	int unsigned            credit_due [$];
	int unsigned            now;

	// never-written words follow the address pattern
	function automatic logic [`DATA_WIDTH-1:0] read_word(input logic [`ADDR_WIDTH-1:0] addr);
		if (store.exists(addr))
			return store[addr];
		return 32'(addr) ^ 32'hA5A5_0000;
	endfunction

	always @(posedge clock_i) begin
		if (rst_i) begin
			now = 0;
			beats.delete();
			credit_due.delete();
			mem_credit_o <= 1'b0;
			mem_valid_o  <= 1'b0;
			mem_data_o   <= '0;
		end else begin
			now = now + 1;
			if (mem_req_i) begin
				credit_due.push_back(now + credit_delay_i);
				if (mem_rw_i)
					store[mem_add_i] = mem_data_i;
				else if (mem_block_i)
					for (int k = 0; k < `BLOCK_WORDS; k++)
						beats.push_back(read_word(mem_add_i + `ADDR_WIDTH'(k)));
			end
			// at most one credit per cycle
			mem_credit_o <= 1'b0;
			if ((credit_due.size() != 0) && (credit_due[0] <= now)) begin
				void'(credit_due.pop_front());
				mem_credit_o <= 1'b1;
			end
			// read beats return in request order
			mem_valid_o <= 1'b0;
			if (beats.size() != 0) begin
				mem_valid_o <= 1'b1;
				mem_data_o  <= beats.pop_front();
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_internal_memory_system.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "cache_settings.svh"

module tb_internal_memory_system;

	localparam int CYCLE_LIMIT = 20000;

	logic                   clock = 1'b0;
	logic                   rst;
	logic                   i_req, i_rw, d_req, d_rw;
	logic [`ADDR_WIDTH-1:0] i_add, d_add;
	logic [`DATA_WIDTH-1:0] i_wdata, d_wdata;
	wire                    i_done, d_done;
	wire  [`DATA_WIDTH-1:0] i_rdata, d_rdata;
	wire                    mem_req, mem_rw, mem_block, mem_credit, mem_valid;
	wire  [`ADDR_WIDTH-1:0] mem_add;
	wire  [`DATA_WIDTH-1:0] mem_wdata, mem_rdata;
	logic [31:0]            credit_delay;
	integer                 seed;
	int                     errors = 0;
	int                     cycles = 0;
	int                     req_count = 0;
	int                     credit_count = 0;
	int                     max_out = 0;
	logic                   last_rw, last_block;
	logic [`ADDR_WIDTH-1:0] last_add;
	logic [`DATA_WIDTH-1:0] last_data;
	// words the testbench has written, by address
	logic [`DATA_WIDTH-1:0] written [logic [`ADDR_WIDTH-1:0]];

	internal_memory_system i_dut (
		.clock_i(clock), .rst_i(rst),
		.i_core_req_i(i_req), .i_core_rw_i(i_rw), .i_core_add_i(i_add),
		.i_core_data_i(i_wdata), .i_core_done_o(i_done), .i_core_data_o(i_rdata),
		.d_core_req_i(d_req), .d_core_rw_i(d_rw), .d_core_add_i(d_add),
		.d_core_data_i(d_wdata), .d_core_done_o(d_done), .d_core_data_o(d_rdata),
		.mem_req_o(mem_req), .mem_rw_o(mem_rw), .mem_block_o(mem_block),
		.mem_add_o(mem_add), .mem_data_o(mem_wdata), .mem_credit_i(mem_credit),
		.mem_valid_i(mem_valid), .mem_data_i(mem_rdata)
	);

	ext_memory_model mem_model (
		.clock_i(clock), .rst_i(rst), .credit_delay_i(credit_delay),
		.mem_req_i(mem_req), .mem_rw_i(mem_rw), .mem_block_i(mem_block),
		.mem_add_i(mem_add), .mem_data_i(mem_wdata), .mem_credit_o(mem_credit),
		.mem_valid_o(mem_valid), .mem_data_o(mem_rdata)
	);

	always #50 clock = ~clock;

	// external port monitor and cycle limit
	// ----------------------------------------------------------------------
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (mem_req) begin
			req_count  <= req_count + 1;
			last_rw    <= mem_rw;
			last_block <= mem_block;
			last_add   <= mem_add;
			last_data  <= mem_wdata;
		end
		if (mem_credit)
			credit_count <= credit_count + 1;
		if ((req_count - credit_count) > max_out)
			max_out <= req_count - credit_count;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run exceeded %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [`DATA_WIDTH-1:0] expected_word(input logic [`ADDR_WIDTH-1:0] addr);
		if (written.exists(addr))
			return written[addr];
		return 32'(addr) ^ 32'hA5A5_0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// one core request on either port, held until done
	task automatic access(input logic dport, input logic rw, input logic [`ADDR_WIDTH-1:0] addr,
		input logic [`DATA_WIDTH-1:0] wdata, output logic [`DATA_WIDTH-1:0] rdata);
		logic done;
		@(negedge clock);
		if (dport) begin
			d_req   = 1'b1;
			d_rw    = rw;
			d_add   = addr;
			d_wdata = wdata;
		end else begin
			i_req   = 1'b1;
			i_rw    = rw;
			i_add   = addr;
			i_wdata = wdata;
		end
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			done = dport ? d_done : i_done;
		end
		rdata = dport ? d_rdata : i_rdata;
		if (dport)
			d_req = 1'b0;
		else
			i_req = 1'b0;
		if (rw)
			written[addr] = wdata;
	endtask

	task automatic read_and_check(input logic dport, input logic [`ADDR_WIDTH-1:0] addr,
		input string name);
		logic [`DATA_WIDTH-1:0] rdata;
		access(dport, 1'b0, addr, '0, rdata);
		check_value(name, expected_word(addr), rdata);
	endtask

	task automatic wait_credits_home();
		while (req_count != credit_count) begin
			@(negedge clock);
		end
	endtask

	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_reset_cold_miss();
		repeat (8) @(negedge clock);
		check_value("reset idle requests", 0, req_count);
		check_value("reset done flags", 0, 32'({i_done, d_done}));
		read_and_check(1'b1, 24'h001235, "cold miss data");
		check_value("cold miss requests", 1, req_count);
		check_value("cold miss block", 1, 32'(last_block));
		check_value("cold miss address", 32'h001234, 32'(last_add));
	endtask

	task automatic test_hit();
		int base;
		base = req_count;
		read_and_check(1'b1, 24'h001234, "hit word 0");
		read_and_check(1'b1, 24'h001236, "hit word 2");
		read_and_check(1'b1, 24'h001237, "hit word 3");
		check_value("hit requests", 0, req_count - base);
	endtask

	task automatic test_write_through();
		int                     base;
		logic [`DATA_WIDTH-1:0] rdata;
		base = req_count;
		access(1'b1, 1'b1, 24'h001236, 32'h5EED_C0DE, rdata);
		check_value("write requests", 1, req_count - base);
		check_value("write rw", 1, 32'(last_rw));
		check_value("write block", 0, 32'(last_block));
		check_value("write address", 32'h001236, 32'(last_add));
		check_value("write data", 32'h5EED_C0DE, last_data);
		read_and_check(1'b1, 24'h001236, "read after write");
		check_value("read after write requests", 1, req_count - base);
	endtask

	task automatic test_fifo_replacement();
		int base;
		// three blocks in set 5
		read_and_check(1'b1, 24'h010014, "fifo block A");
		read_and_check(1'b1, 24'h010115, "fifo block B");
		read_and_check(1'b1, 24'h010216, "fifo block C");
		base = req_count;
		read_and_check(1'b1, 24'h010117, "fifo B hit");
		check_value("fifo B requests", 0, req_count - base);
		read_and_check(1'b1, 24'h010017, "fifo A refill");
		check_value("fifo A requests", 1, req_count - base);
		check_value("fifo A address", 32'h010014, 32'(last_add));
	endtask

	task automatic test_concurrent_ports();
		logic [`ADDR_WIDTH-1:0] i_list [8];
		logic [`ADDR_WIDTH-1:0] d_list [8];
		for (int n = 0; n < 8; n++) begin
			i_list[n] = {4'h2, 20'($random(seed))};
			d_list[n] = {4'h3, 20'($random(seed))};
		end
		for (int n = 0; n < 8; n++) begin
			// credits often lag behind the next pair of misses
			credit_delay = 8 + ($unsigned($random(seed)) % 24);
			fork
				read_and_check(1'b0, i_list[n], "concurrent icache");
				read_and_check(1'b1, d_list[n], "concurrent dcache");
			join
		end
		wait_credits_home();
		check_value("outstanding within credits", 1, 32'(max_out <= `MEM_CREDITS));
	endtask

	task automatic test_back_pressure();
		int                     base;
		logic                   i_finished;
		logic                   d_finished;
		logic [`DATA_WIDTH-1:0] rdata;
		wait_credits_home();
		credit_delay = 50;
		// two writes use up both credits
		access(1'b1, 1'b1, 24'h400010, 32'h0BAD_F00D, rdata);
		access(1'b1, 1'b1, 24'h400011, 32'h1234_ABCD, rdata);
		base       = req_count;
		i_finished = 1'b0;
		d_finished = 1'b0;
		fork
			begin
				read_and_check(1'b0, 24'h400010, "stalled icache read");
				i_finished = 1'b1;
			end
			begin
				read_and_check(1'b1, 24'h400011, "stalled dcache read");
				d_finished = 1'b1;
			end
			begin
				repeat (35) @(negedge clock);
				check_value("requests without credits", 0, req_count - base);
				check_value("reads done without credits", 0, 32'({i_finished, d_finished}));
			end
		join
		check_value("requests after credits", 2, req_count - base);
	endtask

	initial begin
		rst          = 1'b1;
		i_req        = 1'b0;
		i_rw         = 1'b0;
		i_add        = '0;
		i_wdata      = '0;
		d_req        = 1'b0;
		d_rw         = 1'b0;
		d_add        = '0;
		d_wdata      = '0;
		credit_delay = 2;
		seed         = 32'h176c5d96;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		test_reset_cold_miss();
		test_hit();
		test_write_through();
		test_fifo_replacement();
		test_concurrent_ports();
		test_back_pressure();
		wait_credits_home();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== internal_memory_system.f ====
+incdir+common
common/cache_pkg.sv
cache/cache_two_way_fifo.sv
verilog/memory_arbiter.sv
verilog/internal_memory_system.sv
verif/ext_memory_model.sv
verif/tb_internal_memory_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_internal_memory_system \
	-f internal_memory_system.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
